// File: all.f
+incdir+hw
hw/pet_pkg.sv
hw/timing.sv
hw/host_bridge.sv
hw/video_fetch.sv
hw/arbiter.sv
hw/ram.sv
hw/bus_main.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_top.sv

// File: Makefile
# Verilator build of the trace testbench, run it from the project root
SIM := obj_dir/Vtb_top

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

$(SIM): all.f $(wildcard hw/*.sv hw/*.svh dv/*.sv)
	verilator --binary --timing -Wno-fatal --top-module tb_top -f all.f

clean:
	rm -rf obj_dir

// File: dv/bus_trace.txt
# Columns: op (R read, W write), address in hex, data in hex
# For W the data is written, for R it is the byte the read must return
R 00000 5A
R 00123 78
W 00123 C3
R 00123 C3
R 1ABCD 3D
W 08002 41
W 08005 42
R 08002 41
R 08004 DE
W 1FFFF 00
R 1FFFF 00
R 0FF00 A5
W 08009 7E
R 08009 7E
W 0800C 99
R 0800D D7
R 10055 0E
R 08005 42

// File: dv/tb_top.sv
// Trace-driven testbench; dv/bus_trace.txt is opened relative to the run directory
`timescale 1ns/1ps
`include "pet_cfg.svh"

module tb_top;
    localparam int          AW        = `PET_WB_ADDR_WIDTH;
    localparam int          DW        = `PET_DATA_WIDTH;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;     // x^32 + x^22 + x^2 + x + 1

    logic          sys_clock;
    logic          sys_reset_n;
    logic          host_valid;
    logic          host_ready;
    logic          host_we;
    logic [AW-1:0] host_addr;
    logic [DW-1:0] host_wdata;
    logic [DW-1:0] host_rdata;
    logic          host_done;
    logic [DW-1:0] exp_rdata;
    logic [DW-1:0] video_char;
    logic          video_valid;
    logic          cpu_grant;
    logic [AW-1:0] ram_addr;
    logic [DW-1:0] ram_rdata;
    logic [DW-1:0] ram_wdata;
    logic          ram_data_oe;
    logic          ram_oe;
    logic          ram_we;
    logic          report_req;
    int            error_count;
    int            video_fetches;
    int            cycle_count;
    int            cycle_limit;
    logic [31:0]   lfsr;

    logic [DW-1:0] sram [0:(1<<AW)-1];
    logic          trace_we   [$];
    logic [AW-1:0] trace_addr [$];
    logic [DW-1:0] trace_data [$];

    tb_clock i_tb_clock (
        .sys_clock_o (sys_clock),
        .sys_reset_no(sys_reset_n)
    );

    bus_main i_bus_main (
        .sys_clock_i  (sys_clock),
        .sys_reset_ni (sys_reset_n),
        .host_valid_i (host_valid),
        .host_ready_o (host_ready),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_rdata_o (host_rdata),
        .host_done_o  (host_done),
        .video_char_o (video_char),
        .video_valid_o(video_valid),
        .cpu_grant_o  (cpu_grant),
        .ram_addr_o   (ram_addr),
        .ram_data_i   (ram_rdata),
        .ram_data_o   (ram_wdata),
        .ram_data_oe_o(ram_data_oe),
        .ram_oe_o     (ram_oe),
        .ram_we_o     (ram_we)
    );

    tb_checker i_tb_checker (
        .sys_clock_i    (sys_clock),
        .sys_reset_ni   (sys_reset_n),
        .host_valid_i   (host_valid),
        .host_ready_i   (host_ready),
        .host_we_i      (host_we),
        .host_addr_i    (host_addr),
        .host_wdata_i   (host_wdata),
        .host_rdata_i   (host_rdata),
        .host_done_i    (host_done),
        .exp_rdata_i    (exp_rdata),
        .video_char_i   (video_char),
        .video_valid_i  (video_valid),
        .cpu_grant_i    (cpu_grant),
        .ram_addr_i     (ram_addr),
        .ram_data_i     (ram_wdata),
        .ram_data_oe_i  (ram_data_oe),
        .ram_oe_i       (ram_oe),
        .ram_we_i       (ram_we),
        .report_i       (report_req),
        .error_count_o  (error_count),
        .video_fetches_o(video_fetches)
    );

    // SRAM model with asynchronous read, data bus pulled high while OE is low
    assign ram_rdata = ram_oe ? sram[ram_addr] : '1;

    always @(posedge sys_clock) begin
        if (ram_we) sram[ram_addr] = ram_wdata;
    end

    initial begin
        for (int a = 0; a < (1 << AW); a++) begin
            sram[a] = 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16) ^ 8'h5A;   // Whole address in the fill
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ LFSR_TAPS;
        return n;
    endfunction

    // Idle gap of 0 to 15 cycles, one LFSR step per bit
    task automatic take_gap(output int gap);
        gap = 0;
        repeat (4) begin
            gap  = (gap << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic load_trace(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       op;
        logic [31:0] addr_v;
        logic [31:0] data_v;
        ok = 1'b0;
        fd = $fopen("dv/bus_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%s %h %h", op, addr_v, data_v);
                if (n == 3 && (op == "R" || op == "W")) begin   // Comments and blanks fall out
                    trace_we.push_back(op == "W");
                    trace_addr.push_back(addr_v[AW-1:0]);
                    trace_data.push_back(data_v[DW-1:0]);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic do_request(input logic we, input logic [AW-1:0] addr,
                              input logic [DW-1:0] data);
        @(negedge sys_clock);
        host_valid = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = we ? data : '0;
        exp_rdata  = we ? '0 : data;
        while (!host_ready) @(negedge sys_clock);   // Taken at the next rising edge
        @(negedge sys_clock);
        host_valid = 1'b0;
        while (!host_done) @(negedge sys_clock);
    endtask

    initial begin
        bit loaded;
        int gap;
        host_valid  = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        exp_rdata   = '0;
        report_req  = 1'b0;
        cycle_limit = 0;
        lfsr        = 32'd69450;
        load_trace(loaded);
        if (!loaded || trace_we.size() == 0) begin
            $display("Could not read any operation from dv/bus_trace.txt");
            $display("Testbench failed");
            $finish;
        end else begin
            cycle_limit = trace_we.size() * 64 + 2000;
            @(posedge sys_reset_n);
            foreach (trace_we[i]) begin
                take_gap(gap);
                repeat (gap) @(negedge sys_clock);
                do_request(trace_we[i], trace_addr[i], trace_data[i]);
            end
            wait (video_fetches >= 16);     // Screen reads past the written bytes
            @(negedge sys_clock);
            report_req = 1'b1;
            #1;
            if (error_count == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

    // Run limit from the trace length
    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge sys_clock);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles before the trace completed", cycle_count);
        report_req = 1'b1;
        #1;
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: dv/tb_checker.sv
// Watches the DUT ports; the shadow memory follows the SRAM write pins, so only the host may write
`timescale 1ns/1ps
`include "pet_cfg.svh"

module tb_checker (
    input  logic                          sys_clock_i,
    input  logic                          sys_reset_ni,
    input  logic                          host_valid_i,
    input  logic                          host_ready_i,
    input  logic                          host_we_i,
    input  logic [`PET_WB_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [   `PET_DATA_WIDTH-1:0] host_wdata_i,
    input  logic [   `PET_DATA_WIDTH-1:0] host_rdata_i,
    input  logic                          host_done_i,
    input  logic [   `PET_DATA_WIDTH-1:0] exp_rdata_i,      // Trace value of the current read
    input  logic [   `PET_DATA_WIDTH-1:0] video_char_i,
    input  logic                          video_valid_i,
    input  logic                          cpu_grant_i,
    input  logic [`PET_WB_ADDR_WIDTH-1:0] ram_addr_i,
    input  logic [   `PET_DATA_WIDTH-1:0] ram_data_i,       // Byte driven toward the SRAM
    input  logic                          ram_data_oe_i,
    input  logic                          ram_oe_i,
    input  logic                          ram_we_i,
    input  logic                          report_i,
    output int                            error_count_o,
    output int                            video_fetches_o
);
    localparam int AW = `PET_WB_ADDR_WIDTH;
    localparam int DW = `PET_DATA_WIDTH;

    logic [DW-1:0] shadow [0:(1<<AW)-1];
    int            value_errors;
    int            protocol_errors;
    int            host_count;
    int            writes_seen;
    int            run_cycles;      // Rising edges since reset release
    int            cpu_slots;
    logic          busy;            // Host request accepted, done not yet seen
    logic          pend_we;
    logic [AW-1:0] pend_addr;
    logic [DW-1:0] pend_data;       // Write data or expected read data
    logic          we_prev;
    logic [AW-1:0] video_addr;

    // Preload rule of the SRAM model
    function automatic logic [DW-1:0] fill_byte(input logic [AW-1:0] a);
        return a[7:0] ^ a[15:8] ^ {7'd0, a[16]} ^ 8'h5A;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (exp !== got) begin
            value_errors++;
            $display("Fail %s expected %h got %h at %0t ns", name, exp, got, $time);
        end
    endtask

    task automatic protocol_error(input string msg);
        protocol_errors++;
        $display("%s at %0t ns", msg, $time);
    endtask

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
        host_count      = 0;
        writes_seen     = 0;
        run_cycles      = 0;
        cpu_slots       = 0;
        video_fetches_o = 0;
        busy            = 1'b0;
        pend_we         = 1'b0;
        we_prev         = 1'b0;
        for (int a = 0; a < (1 << AW); a++) begin
            shadow[a] = fill_byte(AW'(a));
        end
    end

    assign error_count_o = value_errors + protocol_errors;

    always @(posedge sys_clock_i) begin
        if (!sys_reset_ni) begin
            check_value("host_ready_o", 1, host_ready_i);
            check_value("host_done_o", 0, host_done_i);
            check_value("video_valid_o", 0, video_valid_i);
            check_value("cpu_grant_o", 0, cpu_grant_i);
            check_value("ram_oe_o", 0, ram_oe_i);
            check_value("ram_we_o", 0, ram_we_i);
            check_value("ram_data_oe_o", 0, ram_data_oe_i);
        end else begin
            run_cycles++;
            if (ram_oe_i && ram_we_i) protocol_error("ram_oe_o and ram_we_o are high together");
            if (cpu_grant_i && (ram_oe_i || ram_we_i)) begin
                protocol_error("cpu_grant_o is high during an SRAM access");
            end
            if (ram_we_i) check_value("ram_data_oe_o", 1, ram_data_oe_i);

            // CPU slot on every 8th edge after reset
            if (cpu_grant_i) begin
                if (run_cycles % 8 != 0) begin
                    protocol_error("cpu_grant_o is high outside a CPU slot");
                end
                cpu_slots++;
            end

            // First cycle of each SRAM write
            if (ram_we_i && !we_prev) begin
                if (busy && pend_we) begin
                    check_value("ram_addr_o", pend_addr, ram_addr_i);
                    check_value("ram_data_o", pend_data, ram_data_i);
                    writes_seen++;
                end else begin
                    protocol_error("SRAM write seen with no host write in flight");
                end
                shadow[ram_addr_i] = ram_data_i;
            end
            we_prev = ram_we_i;

            if (host_done_i) begin
                if (!busy) begin
                    protocol_error("host_done_o pulsed without an accepted request");
                end else if (pend_we) begin
                    if (writes_seen != 1) begin
                        protocol_error($sformatf("Host write ended after %0d SRAM writes",
                                                 writes_seen));
                    end
                end else begin
                    check_value("host_rdata_o", pend_data, host_rdata_i);
                end
                busy = 1'b0;
                host_count++;
            end else if (busy && host_ready_i) begin
                protocol_error("host_ready_o rose before host_done_o");
            end

            if (host_valid_i && host_ready_i) begin
                busy        = 1'b1;
                pend_we     = host_we_i;
                pend_addr   = host_addr_i;
                pend_data   = host_we_i ? host_wdata_i : exp_rdata_i;
                writes_seen = 0;
                if (!host_we_i && exp_rdata_i !== shadow[host_addr_i]) begin
                    protocol_error($sformatf("Trace expects %h at %h but memory holds %h",
                                             exp_rdata_i, host_addr_i, shadow[host_addr_i]));
                end
            end

            // Only completed fetches move the screen position
            if (video_valid_i) begin
                video_addr = AW'(`PET_VIDEO_BASE) + AW'(video_fetches_o % `PET_VIDEO_CHARS);
                check_value("video_char_o", shadow[video_addr], video_char_i);
                video_fetches_o++;
            end
        end
    end

    always @(posedge report_i) begin
        if (cpu_slots == 0) protocol_error("cpu_grant_o never went high");
        $display("%0d value errors, %0d protocol errors, %0d host requests, %0d video fetches",
                 value_errors, protocol_errors, host_count, video_fetches_o);
    end

endmodule

// File: dv/tb_clock.sv
// 8 ns clock; reset held low for the first 10 rising edges and released on a falling edge
`timescale 1ns/1ps

module tb_clock (
    output logic sys_clock_o,
    output logic sys_reset_no
);
    initial begin
        sys_clock_o  = 1'b0;
        sys_reset_no = 1'b0;
        repeat (10) @(posedge sys_clock_o);
        @(negedge sys_clock_o);
        sys_reset_no = 1'b1;    // Away from the active edge
    end

    always #4 sys_clock_o = ~sys_clock_o;

endmodule

// File: hw/bus_main.sv
// Memory bus core top; SRAM data pins are split in and out, tristate is left to the pad ring
`timescale 1ns/1ps
`include "pet_cfg.svh"

module bus_main (
    input  logic                          sys_clock_i,     // 64 MHz
    input  logic                          sys_reset_ni,

    // Host requests from the SPI front end
    input  logic                          host_valid_i,
    output logic                          host_ready_o,
    input  logic                          host_we_i,
    input  logic [`PET_WB_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [   `PET_DATA_WIDTH-1:0] host_wdata_i,
    output logic [   `PET_DATA_WIDTH-1:0] host_rdata_o,
    output logic                          host_done_o,

    output logic [   `PET_DATA_WIDTH-1:0] video_char_o,
    output logic                          video_valid_o,
    output logic                          cpu_grant_o,

    // SRAM
    output logic [`PET_WB_ADDR_WIDTH-1:0] ram_addr_o,
    input  logic [   `PET_DATA_WIDTH-1:0] ram_data_i,
    output logic [   `PET_DATA_WIDTH-1:0] ram_data_o,
    output logic                          ram_data_oe_o,
    output logic                          ram_oe_o,
    output logic                          ram_we_o
);
    logic clk8_en;
    logic clk1_en;

    // Shared bus, ack and read data fan out to both controllers
    logic [`PET_WB_ADDR_WIDTH-1:0] wb_addr;
    logic [   `PET_DATA_WIDTH-1:0] wb_dout;     // Controller to RAM
    logic [   `PET_DATA_WIDTH-1:0] wb_din;      // RAM to controllers
    logic                          wb_we;
    logic                          wb_cycle;
    logic                          wb_strobe;
    logic                          wb_stall;
    logic                          wb_ack;

    logic [`PET_WB_ADDR_WIDTH-1:0] host_addr;
    logic [   `PET_DATA_WIDTH-1:0] host_dout;
    logic                          host_we;
    logic                          host_cycle;
    logic                          host_strobe;
    logic                          host_stall;

    logic [`PET_WB_ADDR_WIDTH-1:0] video_addr;
    logic                          video_cycle;
    logic                          video_strobe;
    logic                          video_stall;

    timing i_timing (
        .sys_clock_i (sys_clock_i),
        .sys_reset_ni(sys_reset_ni),
        .clk16_en_o  (),                // Pixel rate, for the shifter outside this core
        .clk8_en_o   (clk8_en),
        .clk1_en_o   (clk1_en)
    );

    host_bridge i_host_bridge (
        .sys_clock_i (sys_clock_i),
        .sys_reset_ni(sys_reset_ni),
        .host_valid_i(host_valid_i),
        .host_ready_o(host_ready_o),
        .host_we_i   (host_we_i),
        .host_addr_i (host_addr_i),
        .host_wdata_i(host_wdata_i),
        .host_rdata_o(host_rdata_o),
        .host_done_o (host_done_o),
        .wb_addr_o   (host_addr),
        .wb_data_o   (host_dout),
        .wb_data_i   (wb_din),
        .wb_we_o     (host_we),
        .wb_cycle_o  (host_cycle),
        .wb_strobe_o (host_strobe),
        .wb_stall_i  (host_stall),
        .wb_ack_i    (wb_ack)
    );

    video_fetch i_video_fetch (
        .sys_clock_i  (sys_clock_i),
        .sys_reset_ni (sys_reset_ni),
        .clk1_en_i    (clk1_en),
        .wb_addr_o    (video_addr),
        .wb_data_i    (wb_din),
        .wb_cycle_o   (video_cycle),
        .wb_strobe_o  (video_strobe),
        .wb_stall_i   (video_stall),
        .wb_ack_i     (wb_ack),
        .video_char_o (video_char_o),
        .video_valid_o(video_valid_o)
    );

    arbiter i_arbiter (
        .sys_clock_i   (sys_clock_i),
        .sys_reset_ni  (sys_reset_ni),
        .clk8_en_i     (clk8_en),
        .host_addr_i   (host_addr),
        .host_data_i   (host_dout),
        .host_we_i     (host_we),
        .host_cycle_i  (host_cycle),
        .host_strobe_i (host_strobe),
        .host_stall_o  (host_stall),
        .video_addr_i  (video_addr),
        .video_cycle_i (video_cycle),
        .video_strobe_i(video_strobe),
        .video_stall_o (video_stall),
        .wb_addr_o     (wb_addr),
        .wb_data_o     (wb_dout),
        .wb_we_o       (wb_we),
        .wb_cycle_o    (wb_cycle),
        .wb_strobe_o   (wb_strobe),
        .wb_stall_i    (wb_stall),
        .wb_ack_i      (wb_ack),
        .cpu_grant_o   (cpu_grant_o)
    );

    ram i_ram (
        .sys_clock_i  (sys_clock_i),
        .sys_reset_ni (sys_reset_ni),
        .wb_addr_i    (wb_addr),
        .wb_data_i    (wb_dout),
        .wb_data_o    (wb_din),
        .wb_we_i      (wb_we),
        .wb_cycle_i   (wb_cycle),
        .wb_strobe_i  (wb_strobe),
        .wb_stall_o   (wb_stall),
        .wb_ack_o     (wb_ack),
        .ram_addr_o   (ram_addr_o),
        .ram_data_i   (ram_data_i),
        .ram_data_o   (ram_data_o),
        .ram_data_oe_o(ram_data_oe_o),
        .ram_oe_o     (ram_oe_o),
        .ram_we_o     (ram_we_o)
    );

endmodule

// File: hw/ram.sv
// Wishbone to async SRAM bridge; fixed access length, one transaction in flight
`timescale 1ns/1ps
`include "pet_cfg.svh"

module ram (
    input  logic                          sys_clock_i,
    input  logic                          sys_reset_ni,

    // Wishbone target
    input  logic [`PET_WB_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [   `PET_DATA_WIDTH-1:0] wb_data_i,
    output logic [   `PET_DATA_WIDTH-1:0] wb_data_o,
    input  logic                          wb_we_i,
    input  logic                          wb_cycle_i,
    input  logic                          wb_strobe_i,
    output logic                          wb_stall_o,
    output logic                          wb_ack_o,

    // SRAM pins
    output logic [`PET_WB_ADDR_WIDTH-1:0] ram_addr_o,
    input  logic [   `PET_DATA_WIDTH-1:0] ram_data_i,
    output logic [   `PET_DATA_WIDTH-1:0] ram_data_o,
    output logic                          ram_data_oe_o,
    output logic                          ram_oe_o,
    output logic                          ram_we_o
);
    localparam int CNT_W = $clog2(`PET_RAM_CYCLES + 1);

    pet_pkg::ram_state_e state;

    logic [CNT_W-1:0] access_cnt;
    logic             we_r;
    logic             accept;
    logic             last_access;

    assign accept      = wb_cycle_i && wb_strobe_i && (state == pet_pkg::RAM_IDLE);
    assign last_access = (state == pet_pkg::RAM_ACCESS)
                         && (access_cnt == CNT_W'(`PET_RAM_CYCLES - 1));

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            state      <= pet_pkg::RAM_IDLE;
            access_cnt <= '0;
        end else begin
            case (state)
                pet_pkg::RAM_IDLE: begin
                    if (accept) begin
                        state      <= pet_pkg::RAM_ACCESS;
                        access_cnt <= '0;
                    end
                end
                pet_pkg::RAM_ACCESS: begin
                    if (last_access) state <= pet_pkg::RAM_ACK;
                    access_cnt <= access_cnt + 1'b1;
                end
                default: state <= pet_pkg::RAM_IDLE;  // Ack lasts one cycle
            endcase
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            ram_addr_o <= wb_addr_i;
            ram_data_o <= wb_data_i;
            we_r       <= wb_we_i;
        end
        if (last_access) wb_data_o <= ram_data_i;   // SRAM output settled by now
    end

    assign ram_oe_o      = (state == pet_pkg::RAM_ACCESS) && !we_r;
    assign ram_we_o      = (state == pet_pkg::RAM_ACCESS) && we_r;
    assign ram_data_oe_o = ram_we_o;
    assign wb_stall_o    = (state != pet_pkg::RAM_IDLE);
    assign wb_ack_o      = (state == pet_pkg::RAM_ACK);

endmodule

// File: hw/arbiter.sv
// Two-controller Wishbone arbiter; video has priority and no grant starts on a CPU slot
`timescale 1ns/1ps
`include "pet_cfg.svh"

module arbiter (
    input  logic                          sys_clock_i,
    input  logic                          sys_reset_ni,
    input  logic                          clk8_en_i,

    // Host controller
    input  logic [`PET_WB_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [   `PET_DATA_WIDTH-1:0] host_data_i,
    input  logic                          host_we_i,
    input  logic                          host_cycle_i,
    input  logic                          host_strobe_i,
    output logic                          host_stall_o,

    // Video controller
    input  logic [`PET_WB_ADDR_WIDTH-1:0] video_addr_i,
    input  logic                          video_cycle_i,
    input  logic                          video_strobe_i,
    output logic                          video_stall_o,

    // Shared bus to the RAM bridge
    output logic [`PET_WB_ADDR_WIDTH-1:0] wb_addr_o,
    output logic [   `PET_DATA_WIDTH-1:0] wb_data_o,
    output logic                          wb_we_o,
    output logic                          wb_cycle_o,
    output logic                          wb_strobe_o,
    input  logic                          wb_stall_i,
    input  logic                          wb_ack_i,

    output logic                          cpu_grant_o
);
    pet_pkg::grant_e grant;

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            grant <= pet_pkg::GRANT_NONE;
        end else if (grant == pet_pkg::GRANT_NONE) begin
            if (!clk8_en_i) begin
                if (video_cycle_i) begin
                    grant <= pet_pkg::GRANT_VIDEO;     // Video wins a tie
                end else if (host_cycle_i) begin
                    grant <= pet_pkg::GRANT_HOST;
                end
            end
        end else if (wb_ack_i) begin
            grant <= pet_pkg::GRANT_NONE;              // Free again next cycle
        end
    end

    always_comb begin
        wb_addr_o   = host_addr_i;
        wb_data_o   = host_data_i;
        wb_we_o     = 1'b0;
        wb_cycle_o  = 1'b0;
        wb_strobe_o = 1'b0;
        case (grant)
            pet_pkg::GRANT_VIDEO: begin
                wb_addr_o   = video_addr_i;
                wb_cycle_o  = video_cycle_i;
                wb_strobe_o = video_strobe_i;
            end
            pet_pkg::GRANT_HOST: begin
                wb_we_o     = host_we_i;
                wb_cycle_o  = host_cycle_i;
                wb_strobe_o = host_strobe_i;
            end
            default: ;
        endcase
    end

    // Non-owners see a stalled bus
    assign video_stall_o = (grant == pet_pkg::GRANT_VIDEO) ? wb_stall_i : 1'b1;
    assign host_stall_o  = (grant == pet_pkg::GRANT_HOST)  ? wb_stall_i : 1'b1;

    assign cpu_grant_o = clk8_en_i && (grant == pet_pkg::GRANT_NONE);

endmodule

// File: hw/video_fetch.sv
// Screen character reader; a tick arriving mid-fetch is dropped and the index holds
`timescale 1ns/1ps
`include "pet_cfg.svh"

module video_fetch (
    input  logic                          sys_clock_i,
    input  logic                          sys_reset_ni,
    input  logic                          clk1_en_i,        // Character tick

    // Wishbone controller, read only
    output logic [`PET_WB_ADDR_WIDTH-1:0] wb_addr_o,
    input  logic [   `PET_DATA_WIDTH-1:0] wb_data_i,
    output logic                          wb_cycle_o,
    output logic                          wb_strobe_o,
    input  logic                          wb_stall_i,
    input  logic                          wb_ack_i,

    output logic [   `PET_DATA_WIDTH-1:0] video_char_o,
    output logic                          video_valid_o
);
    localparam int AW    = `PET_WB_ADDR_WIDTH;
    localparam int IDX_W = $clog2(`PET_VIDEO_CHARS);

    pet_pkg::wb_ctl_state_e state;

    logic [IDX_W-1:0] char_idx;    // Position on screen
    logic             fetch_done;

    assign fetch_done = (state == pet_pkg::WB_WAIT_ACK) && wb_ack_i;

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            state         <= pet_pkg::WB_IDLE;
            char_idx      <= '0;
            video_valid_o <= 1'b0;
        end else begin
            video_valid_o <= fetch_done;
            case (state)
                pet_pkg::WB_IDLE: begin
                    if (clk1_en_i) state <= pet_pkg::WB_REQUEST;
                end
                pet_pkg::WB_REQUEST: begin
                    if (!wb_stall_i) state <= pet_pkg::WB_WAIT_ACK;
                end
                pet_pkg::WB_WAIT_ACK: begin
                    if (wb_ack_i) state <= pet_pkg::WB_IDLE;
                end
                default: state <= pet_pkg::WB_IDLE;
            endcase

            // Advance only on completed fetches
            if (fetch_done) begin
                if (char_idx == IDX_W'(`PET_VIDEO_CHARS - 1)) begin
                    char_idx <= '0;
                end else begin
                    char_idx <= char_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (fetch_done) video_char_o <= wb_data_i;
    end

    // Index only moves on ack, so the address is steady for the whole cycle
    assign wb_addr_o   = AW'(`PET_VIDEO_BASE) + AW'(char_idx);
    assign wb_cycle_o  = (state != pet_pkg::WB_IDLE);
    assign wb_strobe_o = (state == pet_pkg::WB_REQUEST);

endmodule

// File: hw/host_bridge.sv
// Host request port to Wishbone; one transaction at a time, new requests wait on host_ready_o
`timescale 1ns/1ps
`include "pet_cfg.svh"

module host_bridge (
    input  logic                          sys_clock_i,
    input  logic                          sys_reset_ni,

    // Host side
    input  logic                          host_valid_i,
    output logic                          host_ready_o,
    input  logic                          host_we_i,
    input  logic [`PET_WB_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [   `PET_DATA_WIDTH-1:0] host_wdata_i,
    output logic [   `PET_DATA_WIDTH-1:0] host_rdata_o,
    output logic                          host_done_o,

    // Wishbone controller
    output logic [`PET_WB_ADDR_WIDTH-1:0] wb_addr_o,
    output logic [   `PET_DATA_WIDTH-1:0] wb_data_o,
    input  logic [   `PET_DATA_WIDTH-1:0] wb_data_i,
    output logic                          wb_we_o,
    output logic                          wb_cycle_o,
    output logic                          wb_strobe_o,
    input  logic                          wb_stall_i,
    input  logic                          wb_ack_i
);
    pet_pkg::wb_ctl_state_e state;

    logic accept;

    assign host_ready_o = (state == pet_pkg::WB_IDLE) && !host_done_o;
    assign accept       = host_valid_i && host_ready_o;

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            state       <= pet_pkg::WB_IDLE;
            host_done_o <= 1'b0;
        end else begin
            host_done_o <= 1'b0;
            case (state)
                pet_pkg::WB_IDLE: begin
                    if (accept) state <= pet_pkg::WB_REQUEST;
                end
                pet_pkg::WB_REQUEST: begin
                    if (!wb_stall_i) state <= pet_pkg::WB_WAIT_ACK;   // Accept cycle
                end
                pet_pkg::WB_WAIT_ACK: begin
                    if (wb_ack_i) begin
                        state       <= pet_pkg::WB_IDLE;
                        host_done_o <= 1'b1;
                    end
                end
                default: state <= pet_pkg::WB_IDLE;
            endcase
        end
    end

    // Request and read data registers
    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            wb_addr_o <= host_addr_i;
            wb_data_o <= host_wdata_i;
            wb_we_o   <= host_we_i;
        end
        if (state == pet_pkg::WB_WAIT_ACK && wb_ack_i) host_rdata_o <= wb_data_i;
    end

    assign wb_cycle_o  = (state != pet_pkg::WB_IDLE);
    assign wb_strobe_o = (state == pet_pkg::WB_REQUEST);

endmodule

// File: hw/timing.sv
// Clock enables for a 64 MHz system clock only; enables are single-cycle and in phase with reset
`timescale 1ns/1ps

module timing (
    input  logic sys_clock_i,
    input  logic sys_reset_ni,
    output logic clk16_en_o,    // One cycle in 4
    output logic clk8_en_o,     // One cycle in 8, CPU slot
    output logic clk1_en_o      // One cycle in 64, character rate
);
    logic [5:0] div_cnt;

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 6'd1;  // Free running, wraps every 64
        end
    end

    // All-ones terms put the first pulse in cycles 4, 8 and 64 after reset
    assign clk16_en_o = &div_cnt[1:0];
    assign clk8_en_o  = &div_cnt[2:0];
    assign clk1_en_o  = &div_cnt;

endmodule

// File: hw/pet_pkg.sv
// State types shared by the bus controllers, the arbiter and the RAM bridge; no parameters here
package pet_pkg;

    // Wishbone controller sequence, used by host_bridge and video_fetch
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_REQUEST,     // Strobe held until stall drops
        WB_WAIT_ACK     // Accepted, cycle held until ack
    } wb_ctl_state_e;

    // Current owner of the shared bus
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_VIDEO,
        GRANT_HOST
    } grant_e;

    // SRAM bridge sequence
    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_ACCESS,     // OE or WE driven to the SRAM
        RAM_ACK
    } ram_state_e;

endpackage

// File: hw/pet_cfg.svh
// Bus widths and screen geometry; values are fixed here, so a smaller screen needs an edit
`ifndef PET_CFG_SVH
`define PET_CFG_SVH

// Wishbone and SRAM address width, covers 128 KB
`define PET_WB_ADDR_WIDTH 17

// Data bus width of the SRAM and both controllers
`define PET_DATA_WIDTH 8

// First byte of screen RAM
`define PET_VIDEO_BASE 'h8000

// 80 x 25 characters before the fetch index wraps
`define PET_VIDEO_CHARS 2000

// SRAM access length in system clock cycles
`define PET_RAM_CYCLES 2

`endif
